//--- hdl/axisMonPkg.sv
// shared widths, register map and types for the AXI4-Stream protocol monitor
package axisMonPkg;

   // stream geometry
   localparam int DATA_BYTES = 4;        // byte lanes carried on tdata
   localparam int ID_WIDTH   = 8;        // tid bits
   localparam int DEST_WIDTH = 4;        // tdest bits
   localparam int USER_WIDTH = 4;        // tuser bits

   localparam int MAX_WAITS  = 16;       // longest legal run of valid without ready
   localparam int CNT_WIDTH  = 16;       // statistics counters wrap at this width

   // wishbone port geometry
   localparam int WB_ADR_WIDTH = 3;      // word address, eight registers
   localparam int WB_DAT_WIDTH = 32;

   typedef logic [DATA_BYTES*8-1:0]   tdata_t;
   typedef logic [DATA_BYTES-1:0]     laneMask_t;   // tstrb and tkeep
   typedef logic [ID_WIDTH-1:0]       tid_t;
   typedef logic [DEST_WIDTH-1:0]     tdest_t;
   typedef logic [USER_WIDTH-1:0]     tuser_t;
   typedef logic [CNT_WIDTH-1:0]      count_t;
   typedef logic [WB_ADR_WIDTH-1:0]   wbAdr_t;
   typedef logic [WB_DAT_WIDTH-1:0]   wbDat_t;

   // register map
   localparam wbAdr_t ADR_STATUS     = 3'd0;   // sticky violation flags
   localparam wbAdr_t ADR_BEATS      = 3'd1;
   localparam wbAdr_t ADR_PACKETS    = 3'd2;
   localparam wbAdr_t ADR_DATA_BYTES = 3'd3;
   localparam wbAdr_t ADR_POS_BYTES  = 3'd4;
   localparam wbAdr_t ADR_NULL_BYTES = 3'd5;
   localparam wbAdr_t ADR_CLEAR      = 3'd6;   // write bit 0 to clear everything

   // everything that must hold still while tvalid waits
   typedef struct packed {
      tdata_t    tdata;
      laneMask_t tstrb;
      laneMask_t tkeep;
      logic      tlast;
      tid_t      tid;
      tdest_t    tdest;
      tuser_t    tuser;
   } axisBeat_t;

   // first member is the msb, so validDrop lands on bit 0
   typedef struct packed {
      logic reservedLane;   // keep low with strobe high
      logic maxWait;        // ready too late
      logic exitReset;      // valid on the first edge out of reset
      logic payloadChange;  // payload moved during a wait
      logic validDrop;      // valid fell before the handshake
   } violation_t;

   typedef struct packed {
      count_t beats;        // accepted transfers
      count_t packets;      // transfers with tlast
      count_t dataBytes;
      count_t posBytes;
      count_t nullBytes;
   } statCounts_t;

   // wishbone classic request from the host
   typedef struct packed {
      logic   cyc;
      logic   stb;
      logic   we;
      wbAdr_t adr;
      wbDat_t datW;
   } wbReq_t;

   typedef enum logic [0:0] {
      WB_IDLE,              // waiting for cyc and stb
      WB_ACK                // single ack cycle
   } wbState_t;

endpackage

//--- hdl/handshakeCheck.sv
`timescale 1ns/10ps
// handshake rule checker for valid hold, payload stability, reset exit and ready timeout
module handshakeCheck import axisMonPkg::*; (
   input  logic       ACLK,
   input  logic       OPT_RESET,
   input  logic       tvalid,
   input  logic       tready,
   input  axisBeat_t  beat,
   output violation_t hsViol        // combinational, sampled by the sticky register
);

   logic      waitNow;               // valid high and ready low right now
   logic      waitPrev;              // a wait was sampled on the last edge
   axisBeat_t beatPrev;              // payload seen on the last edge
   logic      firstPoint;            // high only on the first edge after reset
   count_t    waitRun;               // wait cycles already seen in this run
   logic      runTooLong;            // this wait cycle is past the bound
   logic      beatMoved;             // payload differs from the last edge

   assign waitNow = tvalid & ~tready;

   // wait tracking and reset exit marker
   always_ff @(posedge ACLK) begin
      if (OPT_RESET) begin
         waitPrev   <= 1'b0;
         firstPoint <= 1'b1;         // armed for the release edge
      end else begin
         waitPrev   <= waitNow;
         firstPoint <= 1'b0;         // one shot
      end
   end

   // payload history, compared only behind a wait
   always_ff @(posedge ACLK) begin
      beatPrev <= beat;
   end

   // run length of consecutive waits
   always_ff @(posedge ACLK) begin
      if (OPT_RESET) begin
         waitRun <= '0;
      end else if (!waitNow) begin
         waitRun <= '0;              // handshake or idle ends the run
      end else if (waitRun <= count_t'(MAX_WAITS)) begin
         waitRun <= waitRun + 1'b1;  // stops at MAX_WAITS+1
      end
   end

   // the MAX_WAITS+1-th wait cycle and beyond
   assign runTooLong = waitNow & (waitRun >= count_t'(MAX_WAITS));

   // whole payload in one compare, tdata through tuser
   assign beatMoved = (beat != beatPrev);

   always_comb begin
      hsViol               = '0;                          // reservedLane stays low here
      hsViol.validDrop     = waitPrev & ~tvalid;           // gave up before ready
      hsViol.payloadChange = waitPrev & tvalid & beatMoved; // still valid, new payload
      hsViol.exitReset     = firstPoint & tvalid;          // valid too early
      hsViol.maxWait       = runTooLong;
   end

endmodule

//--- hdl/transferStats.sv
`timescale 1ns/10ps
// transfer statistics, counts beats, packets and byte classes and flags reserved lanes
module transferStats import axisMonPkg::*; (
   input  logic        ACLK,
   input  logic        OPT_RESET,
   input  logic        clear,         // host clear, wins over a transfer
   input  logic        tvalid,
   input  logic        tready,
   input  axisBeat_t   beat,
   output statCounts_t stats,
   output logic        laneViol       // reserved lane on this transfer
);

   logic      xfer;                   // handshake this cycle
   laneMask_t dataMask;               // keep and strobe high
   laneMask_t posMask;                // keep high, strobe low
   laneMask_t nullMask;               // both low
   laneMask_t rsvMask;                // keep low, strobe high
   count_t    dataInc;
   count_t    posInc;
   count_t    nullInc;
   count_t    pktInc;

   // number of set lanes in a mask
   function automatic count_t popCount(input laneMask_t mask);
      count_t total;
      total = '0;
      for (int i = 0; i < DATA_BYTES; i++) begin
         total = total + count_t'(mask[i]);
      end
      return total;
   endfunction

   assign xfer = tvalid & tready;

   // lane classes from tkeep/tstrb
   assign dataMask = beat.tkeep & beat.tstrb;
   assign posMask  = beat.tkeep & ~beat.tstrb;
   assign nullMask = ~beat.tkeep & ~beat.tstrb;
   assign rsvMask  = ~beat.tkeep & beat.tstrb;

   assign dataInc = popCount(dataMask);
   assign posInc  = popCount(posMask);
   assign nullInc = popCount(nullMask);
   assign pktInc  = count_t'(beat.tlast);   // packet boundary

   // only accepted beats matter
   assign laneViol = xfer & (|rsvMask);

   // counters wrap on overflow
   always_ff @(posedge ACLK) begin
      if (OPT_RESET || clear) begin
         stats <= '0;
      end else if (xfer) begin
         stats.beats     <= stats.beats + 1'b1;
         stats.packets   <= stats.packets + pktInc;
         stats.dataBytes <= stats.dataBytes + dataInc;
         stats.posBytes  <= stats.posBytes + posInc;
         stats.nullBytes <= stats.nullBytes + nullInc;   // reserved lanes count nowhere
      end
   end

endmodule

//--- hdl/monControl.sv
`timescale 1ns/10ps
// wishbone classic slave with sticky violation status, counter readback and clear command
module monControl import axisMonPkg::*; (
   input  logic        ACLK,
   input  logic        OPT_RESET,
   // host side
   input  wbReq_t      wbReq,
   output wbDat_t      wbDatR,        // valid in the ack cycle
   output logic        wbAck,
   // monitor side
   input  violation_t  hsViol,
   input  logic        laneViol,
   input  statCounts_t stats,
   output logic        clear          // one cycle, to the datapath blocks
);

   wbState_t   state;
   logic       reqSeen;               // cyc and stb both high
   logic       clearHit;              // write to the clear register
   violation_t newViol;               // all rule hits this cycle
   violation_t sticky;                // accumulated since reset or clear

   assign reqSeen = wbReq.cyc & wbReq.stb;

   // classic single-cycle ack
   always_ff @(posedge ACLK) begin
      if (OPT_RESET) begin
         state <= WB_IDLE;
      end else begin
         case (state)
            WB_IDLE: begin
               if (reqSeen) begin
                  state <= WB_ACK;    // ack next cycle
               end
            end
            WB_ACK: begin
               state <= WB_IDLE;      // master drops stb after ack
            end
            default: begin
               state <= WB_IDLE;
            end
         endcase
      end
   end

   assign wbAck = (state == WB_ACK);

   // write decode, other addresses ignored
   assign clearHit = wbReq.we & (wbReq.adr == ADR_CLEAR) & wbReq.datW[0];
   assign clear    = wbAck & clearHit;

   // merge the lane flag into the handshake flags
   always_comb begin
      newViol              = hsViol;
      newViol.reservedLane = hsViol.reservedLane | laneViol;
   end

   // sticky status, clear beats a same-cycle hit
   always_ff @(posedge ACLK) begin
      if (OPT_RESET) begin
         sticky <= '0;
      end else if (clear) begin
         sticky <= '0;
      end else begin
         sticky <= sticky | newViol;
      end
   end

   // read mux, address held by the master through the ack
   always_comb begin
      wbDatR = '0;                    // unmapped and clear read as zero
      case (wbReq.adr)
         ADR_STATUS: begin
            wbDatR[$bits(violation_t)-1:0] = sticky;
         end
         ADR_BEATS: begin
            wbDatR[CNT_WIDTH-1:0] = stats.beats;
         end
         ADR_PACKETS: begin
            wbDatR[CNT_WIDTH-1:0] = stats.packets;
         end
         ADR_DATA_BYTES: begin
            wbDatR[CNT_WIDTH-1:0] = stats.dataBytes;
         end
         ADR_POS_BYTES: begin
            wbDatR[CNT_WIDTH-1:0] = stats.posBytes;
         end
         ADR_NULL_BYTES: begin
            wbDatR[CNT_WIDTH-1:0] = stats.nullBytes;
         end
         default: begin
            wbDatR = '0;
         end
      endcase
   end

endmodule

//--- hdl/axisMonTop.sv
`timescale 1ns/10ps
// AXI4-Stream passive monitor top, stream checkers and statistics behind a wishbone slave
module axisMonTop import axisMonPkg::*; (
   input  logic      ACLK,
   input  logic      OPT_RESET,      // synchronous, stands in for the link reset
   // observed stream, nothing is driven back
   input  logic      tvalid,
   input  logic      tready,
   input  axisBeat_t beat,
   // host port
   input  wbReq_t    wbReq,
   output wbDat_t    wbDatR,
   output logic      wbAck
);

   violation_t  hsViol;              // handshake rule hits, reservedLane unused
   logic        laneViol;            // reserved tkeep/tstrb lane on a transfer
   statCounts_t stats;               // live counters
   logic        clear;               // one-cycle clear from the host

   handshakeCheck handshakeCheck_i (
      .ACLK      (ACLK),
      .OPT_RESET (OPT_RESET),
      .tvalid    (tvalid),
      .tready    (tready),
      .beat      (beat),
      .hsViol    (hsViol)
   );

   transferStats transferStats_i (
      .ACLK      (ACLK),
      .OPT_RESET (OPT_RESET),
      .clear     (clear),
      .tvalid    (tvalid),
      .tready    (tready),
      .beat      (beat),
      .stats     (stats),
      .laneViol  (laneViol)
   );

   monControl monControl_i (
      .ACLK      (ACLK),
      .OPT_RESET (OPT_RESET),
      .wbReq     (wbReq),
      .wbDatR    (wbDatR),
      .wbAck     (wbAck),
      .hsViol    (hsViol),
      .laneViol  (laneViol),
      .stats     (stats),
      .clear     (clear)
   );

endmodule

//--- verif/tbStimulus.svh
// stimulus and expected register table for the AXI4-Stream monitor testbench
// beat row columns: repeat count, tvalid, tready, tstrb, tkeep, tlast, fresh tdata, flipped tdata
// check row columns: status flags, beats, packets, data, position and null byte counts

typedef enum logic [1:0] {
   ROW_BEAT,                          // drive the stream for reps cycles
   ROW_CHECK,                         // read every register and compare
   ROW_CLEAR                          // host writes the clear command
} rowKind_t;

typedef struct packed {
   rowKind_t    kind;
   logic [4:0]  reps;                 // cycles this row is held
   logic        tvalid;
   logic        tready;
   laneMask_t   tstrb;
   laneMask_t   tkeep;
   logic        tlast;
   logic        fresh;                // draw new tdata on the first cycle
   logic        flip;                 // tdata differs from the held value
   violation_t  expStatus;
   statCounts_t expStats;
} stimRow_t;

stimRow_t stimTable[$];

function automatic stimRow_t beatRow(input int reps, input logic v, input logic r,
                                     input laneMask_t strb, input laneMask_t keep,
                                     input logic last, input logic fresh, input logic flip);
   stimRow_t row;
   row        = '0;
   row.kind   = ROW_BEAT;
   row.reps   = 5'(reps);
   row.tvalid = v;
   row.tready = r;
   row.tstrb  = strb;
   row.tkeep  = keep;
   row.tlast  = last;
   row.fresh  = fresh;
   row.flip   = flip;
   return row;
endfunction

function automatic stimRow_t checkRow(input violation_t status, input int beats,
                                      input int packets, input int dataB,
                                      input int posB, input int nullB);
   stimRow_t row;
   row                    = '0;
   row.kind               = ROW_CHECK;
   row.expStatus          = status;
   row.expStats.beats     = count_t'(beats);
   row.expStats.packets   = count_t'(packets);
   row.expStats.dataBytes = count_t'(dataB);
   row.expStats.posBytes  = count_t'(posB);
   row.expStats.nullBytes = count_t'(nullB);
   return row;
endfunction

function automatic stimRow_t clearRow();
   stimRow_t row;
   row      = '0;
   row.kind = ROW_CLEAR;
   return row;
endfunction

task automatic fillTable();
   // legal traffic, two packets
   stimTable.push_back(beatRow(2, 1'b0, 1'b1, 4'h0, 4'h0, 1'b0, 1'b0, 1'b0)); // ready first
   stimTable.push_back(beatRow(1, 1'b1, 1'b1, 4'hf, 4'hf, 1'b0, 1'b1, 1'b0)); // same cycle
   stimTable.push_back(beatRow(3, 1'b1, 1'b0, 4'hf, 4'hf, 1'b0, 1'b1, 1'b0)); // 3-cycle wait
   stimTable.push_back(beatRow(1, 1'b1, 1'b1, 4'hf, 4'hf, 1'b0, 1'b0, 1'b0)); // 4 data
   stimTable.push_back(beatRow(1, 1'b1, 1'b1, 4'h3, 4'hf, 1'b1, 1'b1, 1'b0)); // 2 data 2 pos
   stimTable.push_back(beatRow(1, 1'b0, 1'b0, 4'h0, 4'h0, 1'b0, 1'b0, 1'b0));
   stimTable.push_back(beatRow(1, 1'b1, 1'b1, 4'h1, 4'h3, 1'b0, 1'b1, 1'b0)); // 1 data 1 pos 2 null
   stimTable.push_back(beatRow(2, 1'b1, 1'b0, 4'h0, 4'hf, 1'b1, 1'b1, 1'b0));
   stimTable.push_back(beatRow(1, 1'b1, 1'b1, 4'h0, 4'hf, 1'b1, 1'b0, 1'b0)); // 4 pos
   stimTable.push_back(checkRow(5'h00, 5, 2, 11, 7, 2));
   // valid drop and payload change
   stimTable.push_back(beatRow(2, 1'b1, 1'b0, 4'hf, 4'hf, 1'b0, 1'b1, 1'b0));
   stimTable.push_back(beatRow(1, 1'b0, 1'b0, 4'hf, 4'hf, 1'b0, 1'b0, 1'b0)); // gave up
   stimTable.push_back(beatRow(2, 1'b1, 1'b0, 4'hf, 4'hf, 1'b0, 1'b1, 1'b0));
   stimTable.push_back(beatRow(1, 1'b1, 1'b0, 4'hf, 4'hf, 1'b0, 1'b0, 1'b1)); // tdata moves
   stimTable.push_back(beatRow(1, 1'b1, 1'b1, 4'hf, 4'hf, 1'b0, 1'b0, 1'b1));
   stimTable.push_back(checkRow(5'h03, 6, 2, 15, 7, 2));
   stimTable.push_back(clearRow());
   stimTable.push_back(checkRow(5'h00, 0, 0, 0, 0, 0));
   // reserved lane 3, lanes 0..2 still counted
   stimTable.push_back(beatRow(1, 1'b1, 1'b1, 4'hd, 4'h7, 1'b1, 1'b1, 1'b0));
   stimTable.push_back(checkRow(5'h10, 1, 1, 2, 1, 0));
   stimTable.push_back(clearRow());
   // ready wait at and past the bound
   stimTable.push_back(beatRow(16, 1'b1, 1'b0, 4'hf, 4'hf, 1'b0, 1'b1, 1'b0)); // MAX_WAITS
   stimTable.push_back(beatRow(1, 1'b1, 1'b1, 4'hf, 4'hf, 1'b0, 1'b0, 1'b0));
   stimTable.push_back(checkRow(5'h00, 1, 0, 4, 0, 0));
   stimTable.push_back(beatRow(17, 1'b1, 1'b0, 4'h0, 4'h0, 1'b1, 1'b1, 1'b0)); // one too many
   stimTable.push_back(beatRow(1, 1'b1, 1'b1, 4'h0, 4'h0, 1'b1, 1'b0, 1'b0)); // 4 null
   stimTable.push_back(checkRow(5'h08, 2, 1, 4, 0, 4));
endtask

//--- verif/tbAxisMon.sv
// testbench for the AXI4-Stream monitor, table-driven stream traffic with wishbone readback
`timescale 1ns/10ps
module tbAxisMon import axisMonPkg::*; ();

   localparam int RESET_CYCLES = 8;
   localparam int DRIVE_DELAY  = 2;        // ns after the rising edge

   logic        ACLK;
   logic        OPT_RESET;
   logic        tvalid;
   logic        tready;
   axisBeat_t   beat;
   wbReq_t      wbReq;
   wbDat_t      wbDatR;
   logic        wbAck;

   logic [31:0] rngState;                 // xorshift state
   logic [31:0] curData;                  // tdata held across a wait
   int          errorCount;
   int          cycleCount;

   `include "tbStimulus.svh"

   axisMonTop dut_i (
      .ACLK      (ACLK),
      .OPT_RESET (OPT_RESET),
      .tvalid    (tvalid),
      .tready    (tready),
      .beat      (beat),
      .wbReq     (wbReq),
      .wbDatR    (wbDatR),
      .wbAck     (wbAck)
   );

   always #20 ACLK = ~ACLK;               // 40 ns period

   function automatic logic [31:0] nextRandom(input logic [31:0] state);
      logic [31:0] s;
      s = state;
      s = s ^ (s << 13);
      s = s ^ (s >> 17);
      s = s ^ (s << 5);
      return s;
   endfunction

   // stream cycles plus four cycles per host access, doubled for margin
   function automatic int timeoutCycles();
      int cycles;
      int reads;
      cycles = RESET_CYCLES + 2;           // second reset and its release edge
      reads  = 2;                          // exit-reset status and unmapped read
      foreach (stimTable[i]) begin
         case (stimTable[i].kind)
            ROW_BEAT:  cycles += int'(stimTable[i].reps);
            ROW_CHECK: reads += 6;
            default:   reads += 1;
         endcase
      end
      return (cycles + 4 * reads + 8) * 2;
   endfunction

   task automatic checkEq(input string name, input wbDat_t actual, input wbDat_t expected);
      if (actual !== expected) begin
         errorCount++;
         $display("Fail %s: read 0x%h, expected 0x%h", name, actual, expected);
         $display("TEST FAILED");
         $fatal(1, "register mismatch");
      end
   endtask

   // one classic cycle, stream idles while the host is on the bus
   task automatic wbAccess(input logic write, input wbAdr_t adr, input wbDat_t datW,
                           output wbDat_t datR);
      int ackDelay;
      @(posedge ACLK);
      #DRIVE_DELAY;
      tvalid     = 1'b0;
      tready     = 1'b0;
      wbReq.cyc  = 1'b1;
      wbReq.stb  = 1'b1;
      wbReq.we   = write;
      wbReq.adr  = adr;
      wbReq.datW = datW;
      ackDelay   = 0;
      do begin
         @(posedge ACLK);
         #1;                               // sample between edge and drive
         ackDelay++;
      end while (!wbAck);
      checkEq("ackDelay", wbDat_t'(ackDelay), 32'd1);   // ack one cycle after the request
      datR = wbDatR;
      @(posedge ACLK);                     // ack seen by the master on this edge
      #DRIVE_DELAY;
      wbReq = '0;                          // drop cyc and stb after ack
      checkEq("wbAck", wbDat_t'(wbAck), '0);             // ack lasts a single cycle
   endtask

   task automatic applyBeatRow(input stimRow_t row);
      for (int i = 0; i < int'(row.reps); i++) begin
         @(posedge ACLK);
         #DRIVE_DELAY;
         if (i == 0 && row.fresh) begin
            rngState = nextRandom(rngState);
            curData  = rngState;
         end
         tvalid     = row.tvalid;
         tready     = row.tready;
         beat.tdata = row.flip ? (curData ^ 32'h00ff_0000) : curData;
         beat.tstrb = row.tstrb;
         beat.tkeep = row.tkeep;
         beat.tlast = row.tlast;
         beat.tid   = curData[7:0];        // sideband follows the held data
         beat.tdest = curData[11:8];
         beat.tuser = curData[15:12];
      end
   endtask

   task automatic checkRegisters(input stimRow_t row);
      wbDat_t rd;
      wbAccess(1'b0, ADR_STATUS, '0, rd);
      checkEq("status", rd, wbDat_t'(row.expStatus));
      wbAccess(1'b0, ADR_BEATS, '0, rd);
      checkEq("beats", rd, wbDat_t'(row.expStats.beats));
      wbAccess(1'b0, ADR_PACKETS, '0, rd);
      checkEq("packets", rd, wbDat_t'(row.expStats.packets));
      wbAccess(1'b0, ADR_DATA_BYTES, '0, rd);
      checkEq("dataBytes", rd, wbDat_t'(row.expStats.dataBytes));
      wbAccess(1'b0, ADR_POS_BYTES, '0, rd);
      checkEq("posBytes", rd, wbDat_t'(row.expStats.posBytes));
      wbAccess(1'b0, ADR_NULL_BYTES, '0, rd);
      checkEq("nullBytes", rd, wbDat_t'(row.expStats.nullBytes));
   endtask

   initial begin
      int cycleLimit;
      #1;                                  // table is filled at time zero
      cycleLimit = timeoutCycles();
      cycleCount = 0;
      while (cycleCount < cycleLimit) begin
         @(posedge ACLK);
         cycleCount++;
      end
      $display("Timeout: no result after %0d clock cycles", cycleLimit);
      $display("TEST FAILED");
      $fatal(1, "simulation timed out");
   end

   initial begin
      stimRow_t row;
      wbDat_t   rd;
      ACLK       = 1'b0;
      OPT_RESET  = 1'b1;
      tvalid     = 1'b0;
      tready     = 1'b0;
      beat       = '0;
      wbReq      = '0;
      rngState   = 32'he00c2504;
      curData    = '0;
      errorCount = 0;
      fillTable();
      repeat (RESET_CYCLES) @(posedge ACLK);
      #DRIVE_DELAY;
      OPT_RESET = 1'b0;                    // release edge sees tvalid low
      foreach (stimTable[i]) begin
         row = stimTable[i];
         case (row.kind)
            ROW_BEAT:  applyBeatRow(row);
            ROW_CHECK: checkRegisters(row);
            default:   wbAccess(1'b1, ADR_CLEAR, 32'h1, rd);
         endcase
      end
      // second reset, tvalid already high on the first edge out of it
      @(posedge ACLK);
      #DRIVE_DELAY;
      tvalid    = 1'b0;
      tready    = 1'b0;
      OPT_RESET = 1'b1;
      repeat (RESET_CYCLES) @(posedge ACLK);
      #DRIVE_DELAY;
      OPT_RESET = 1'b0;
      tvalid    = 1'b1;
      tready    = 1'b1;
      wbAccess(1'b0, ADR_STATUS, '0, rd);
      checkEq("status", rd, 32'h0000_0004);  // exitReset only
      wbAccess(1'b0, 3'd7, '0, rd);
      checkEq("unmapped", rd, '0);
      if (errorCount == 0) begin
         $display("TEST OK");
      end else begin
         $display("TEST FAILED");
      end
      $finish;
   end

endmodule

//--- project.f
+incdir+verif
hdl/axisMonPkg.sv
hdl/handshakeCheck.sv
hdl/transferStats.sv
hdl/monControl.sv
hdl/axisMonTop.sv
verif/tbAxisMon.sv

//--- run.sh
#!/bin/sh
# build and run the AXI4-Stream monitor testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -Wno-fatal --top-module tbAxisMon -f project.f

# keep going on a failing run so the log can be searched
./obj_dir/VtbAxisMon > sim.log 2>&1 || true
cat sim.log

if grep -q "TEST FAILED" sim.log; then
   echo "simulation reported a failure"
   exit 1
fi
grep -q "TEST OK" sim.log
